//--- list.f
rv_pkg.sv
rv_ctrl_if.sv
rv_decoder.sv
rv_regfile.sv
rv_pc.sv
rv_exec.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv

//--- rv_core.sv
module rv_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = rv_pkg::reset_pc_default
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [rv_pkg::xlen-1:0] inst,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  output logic [3:0]              mem_wmask,
  output logic                    mem_ren,
  output logic                    mem_wen,
  input  logic [rv_pkg::xlen-1:0] mem_rdata
);
  import rv_pkg::*;

  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] sum;        // alu result, address and target
  logic [xlen-1:0] wb_data;
  logic [xlen-1:0] load_data;

  rv_ctrl_if ctrl_if ();

  rv_decoder i_decoder (
    .inst (inst),
    .rst  (rst),
    .ctrl (ctrl_if.dec)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .wen      (ctrl_if.reg_wen),
    .waddr    (inst[11:7]),
    .rs1_addr (inst[19:15]),
    .rs2_addr (inst[24:20]),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_pc #(
    .reset_pc (reset_pc)
  ) i_pc (
    .clk      (clk),
    .rst      (rst),
    .jump     (ctrl_if.jump),
    .target   (sum),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  rv_exec i_exec (
    .ctrl      (ctrl_if.user),
    .rs1_data  (rs1_data),
    .pc        (pc),
    .pc_plus4  (pc_plus4),
    .load_data (load_data),
    .sum       (sum),
    .wb_data   (wb_data)
  );

  rv_lsu i_lsu (
    .ctrl      (ctrl_if.user),
    .addr      (sum),
    .rs2_data  (rs2_data),
    .mem_rdata (mem_rdata),
    .load_data (load_data),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask)
  );

  // memory strobes straight from decode
  assign mem_addr = sum;
  assign mem_ren  = ctrl_if.mem_ren;
  assign mem_wen  = ctrl_if.mem_wen;

endmodule

//--- rv_ctrl_if.sv
interface rv_ctrl_if;
  import rv_pkg::*;

  logic [xlen-1:0] imm;     // sign-extended immediate
  src_a_e          src_a;
  wb_sel_e         wb_sel;
  logic            reg_wen;
  logic            mem_ren;
  logic            mem_wen;
  logic            jump;    // pc takes the adder sum
  logic [2:0]      funct3;  // load / store width

  // decoder side
  modport dec (
    output imm, src_a, wb_sel, reg_wen, mem_ren, mem_wen, jump, funct3
  );

  // execute, lsu and top level
  modport user (
    input imm, src_a, wb_sel, reg_wen, mem_ren, mem_wen, jump, funct3
  );

endinterface

//--- rv_decoder.sv
module rv_decoder (
  input  rv_pkg::inst_u inst,
  input  logic          rst,
  rv_ctrl_if.dec        ctrl
);
  import rv_pkg::*;

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  // all forms sign-extend from bit 31
  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_u = {inst.u.imm, 12'h000};
  assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                  inst.j.imm11, inst.j.imm10_1, 1'b0};

  assign ctrl.funct3 = inst.i.funct3;

  always_comb begin
    ctrl.imm     = '0;
    ctrl.src_a   = src_a_rs1;
    ctrl.wb_sel  = wb_add;
    ctrl.reg_wen = 1'b0;
    ctrl.mem_ren = 1'b0;
    ctrl.mem_wen = 1'b0;
    ctrl.jump    = 1'b0;
    case (inst.i.opcode)
      op_imm: begin  // every funct3 handled as addi
        ctrl.imm     = imm_i;
        ctrl.reg_wen = 1'b1;
      end
      op_lui: begin
        ctrl.imm     = imm_u;
        ctrl.src_a   = src_a_zero;
        ctrl.reg_wen = 1'b1;
      end
      op_auipc: begin
        ctrl.imm     = imm_u;
        ctrl.src_a   = src_a_pc;
        ctrl.reg_wen = 1'b1;
      end
      op_jal: begin
        ctrl.imm     = imm_j;
        ctrl.src_a   = src_a_pc;
        ctrl.wb_sel  = wb_link;
        ctrl.reg_wen = 1'b1;
        ctrl.jump    = 1'b1;
      end
      op_jalr: begin  // bit 0 of the target kept
        ctrl.imm     = imm_i;
        ctrl.wb_sel  = wb_link;
        ctrl.reg_wen = 1'b1;
        ctrl.jump    = 1'b1;
      end
      op_load: begin
        ctrl.imm     = imm_i;
        ctrl.wb_sel  = wb_mem;
        ctrl.reg_wen = 1'b1;
        ctrl.mem_ren = 1'b1;
      end
      op_store: begin
        ctrl.imm     = imm_s;
        ctrl.mem_wen = 1'b1;
      end
      default: ;  // unknown opcode, nothing fires
    endcase
    // no side effects while in reset
    if (rst) begin
      ctrl.reg_wen = 1'b0;
      ctrl.mem_ren = 1'b0;
      ctrl.mem_wen = 1'b0;
    end
  end

endmodule

//--- rv_exec.sv
module rv_exec (
  rv_ctrl_if.user                 ctrl,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] pc,
  input  logic [rv_pkg::xlen-1:0] pc_plus4,
  input  logic [rv_pkg::xlen-1:0] load_data,
  output logic [rv_pkg::xlen-1:0] sum,
  output logic [rv_pkg::xlen-1:0] wb_data
);
  import rv_pkg::*;

  logic [xlen-1:0] op_a;

  always_comb begin
    case (ctrl.src_a)
      src_a_pc:   op_a = pc;  // auipc, jal
      src_a_zero: op_a = '0;  // lui
      default:    op_a = rs1_data;
    endcase
  end

  // one adder for result, address and jump target
  assign sum = op_a + ctrl.imm;

  always_comb begin
    case (ctrl.wb_sel)
      wb_link: wb_data = pc_plus4;  // jal / jalr return address
      wb_mem:  wb_data = load_data;
      default: wb_data = sum;
    endcase
  end

endmodule

//--- rv_lsu.sv
module rv_lsu (
  rv_ctrl_if.user                 ctrl,
  input  logic [rv_pkg::xlen-1:0] addr,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,
  output logic [rv_pkg::xlen-1:0] load_data,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  output logic [3:0]              mem_wmask
);
  import rv_pkg::*;

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;
  logic        half_ok;  // halfword aligned
  logic        word_ok;  // word aligned

  assign byte_lane = mem_rdata[{addr[1:0], 3'b000} +: 8];
  assign half_lane = mem_rdata[{addr[1], 4'b0000} +: 16];
  assign half_ok   = ~addr[0];
  assign word_ok   = (addr[1:0] == 2'b00);

  // load extract and extend, misaligned gives zero
  always_comb begin
    load_data = '0;
    case (ctrl.funct3)
      f3_b:  load_data = {{24{byte_lane[7]}}, byte_lane};
      f3_bu: load_data = {24'h00_0000, byte_lane};
      f3_h: begin
        if (half_ok) begin
          load_data = {{16{half_lane[15]}}, half_lane};
        end
      end
      f3_hu: begin
        if (half_ok) begin
          load_data = {16'h0000, half_lane};
        end
      end
      f3_w: begin
        if (word_ok) begin
          load_data = mem_rdata;
        end
      end
      default: ;
    endcase
  end

  // replicate so the addressed lanes always carry the data
  always_comb begin
    case (ctrl.funct3)
      f3_b:    mem_wdata = {4{rs2_data[7:0]}};
      f3_h:    mem_wdata = {2{rs2_data[15:0]}};
      default: mem_wdata = rs2_data;
    endcase
  end

  always_comb begin
    mem_wmask = 4'b0000;
    if (ctrl.mem_wen) begin
      case (ctrl.funct3)
        f3_b: mem_wmask = 4'b0001 << addr[1:0];
        f3_h: begin
          if (half_ok) begin
            mem_wmask = addr[1] ? 4'b1100 : 4'b0011;
          end
        end
        f3_w: begin
          if (word_ok) begin
            mem_wmask = 4'b1111;
          end
        end
        default: ;  // unknown store width, no lanes
      endcase
    end
  end

endmodule

//--- rv_pc.sv
module rv_pc #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = rv_pkg::reset_pc_default
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    jump,
  input  logic [rv_pkg::xlen-1:0] target,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] pc_plus4
);

  assign pc_plus4 = pc + 32'd4;  // static next pc

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (jump) begin
      pc <= target;
    end else begin
      pc <= pc_plus4;
    end
  end

endmodule

//--- rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;

  // pc after reset unless the top level overrides it
  localparam logic [xlen-1:0] reset_pc_default = 32'h8000_0000;

  // kept rv32i major opcodes
  typedef enum logic [6:0] {
    op_imm   = 7'b001_0011,
    op_lui   = 7'b011_0111,
    op_auipc = 7'b001_0111,
    op_jal   = 7'b110_1111,
    op_jalr  = 7'b110_0111,
    op_load  = 7'b000_0011,
    op_store = 7'b010_0011
  } opcode_t;

  // load / store width
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } inst_s_t;

  typedef struct packed {
    logic [19:0] imm;  // upper 20 bits, shifted by 12 on use
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_u_t;

  // j immediate is scrambled in the word
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_j_t;

  typedef union packed {
    inst_i_t i;
    inst_s_t s;
    inst_u_t u;
    inst_j_t j;
  } inst_u;

  typedef enum logic [1:0] {
    src_a_rs1,
    src_a_pc,
    src_a_zero
  } src_a_e;

  typedef enum logic [1:0] {
    wb_add,
    wb_link,
    wb_mem
  } wb_sel_e;

endpackage

//--- rv_regfile.sv
module rv_regfile (
  input  logic                    clk,
  input  logic                    wen,
  input  logic [4:0]              waddr,
  input  logic [4:0]              rs1_addr,
  input  logic [4:0]              rs2_addr,
  input  logic [rv_pkg::xlen-1:0] wdata,
  output logic [rv_pkg::xlen-1:0] rs1_data,
  output logic [rv_pkg::xlen-1:0] rs2_data
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (wen && waddr != 5'd0) begin  // x0 stays unwritten
      regs[waddr] <= wdata;
    end
  end

  // x0 is hardwired to zero on the read side
  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

//--- tb_rv_core.sv
module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam int num_insts = 53;  // instructions issued over all tests

  logic        clk;
  logic        rst;
  logic [31:0] inst;
  logic [31:0] pc;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wmask;
  logic        mem_ren;
  logic        mem_wen;
  logic [31:0] mem_rdata;

  logic [31:0] dmem [256];
  logic [31:0] exp_pc;
  logic [31:0] cur_pc;      // pc of the instruction issued last
  logic [31:0] store_base;
  logic [31:0] store_data;

  rv_core i_rv_core (
    .clk       (clk),
    .rst       (rst),
    .inst      (inst),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_rdata (mem_rdata)
  );

  // word indexed data memory with combinational read
  assign mem_rdata = dmem[mem_addr[9:2]];

  always @(posedge clk) begin
    if (mem_wen) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_wmask[b]) begin
          dmem[mem_addr[9:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #((num_insts + 10) * 20);
    $display("timeout: the core did not get through the tests in the expected time");
    $display("*** TEST FAILED ***");
    $fatal(1);
  end

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'(op_store)};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  // j offset bits land scrambled in the word
  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'(op_jal)};
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  // issues one instruction per cycle and samples outputs on the falling edge
  task automatic run(input logic [31:0] word);
    @(posedge clk);
    inst <= word;
    @(negedge clk);
    check("pc", pc, exp_pc);
    cur_pc = exp_pc;
    exp_pc = exp_pc + 32'd4;
  endtask

  task automatic idle_check();
    check("mem_ren idle", 32'(mem_ren), 32'd0);
    check("mem_wen idle", 32'(mem_wen), 32'd0);
  endtask

  // sw rs, 0(x0) shows the register on mem_wdata
  task automatic store_check(input logic [4:0] rs, input logic [31:0] value);
    run(enc_s(f3_w, 5'd0, rs, 12'h000));
    check("sw strobe", 32'(mem_wen), 32'd1);
    check("sw mask", 32'(mem_wmask), 32'h0000_000f);
    check($sformatf("value of x%0d", rs), mem_wdata, value);
  endtask

  task automatic load_imm(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h0000_0800;  // addi sign-extends the low 12 bits
    run(enc_u(op_lui, rd, hi[31:12]));
    run(enc_i(op_imm, rd, 3'b000, rd, value[11:0]));
  endtask

  task automatic test_reset_and_sequence();
    logic [11:0] imm;
    logic [31:0] expv;
    @(posedge clk);
    @(negedge clk);
    check("mem_ren in reset", 32'(mem_ren), 32'd0);
    check("mem_wen in reset", 32'(mem_wen), 32'd0);
    check("mem_wmask in reset", 32'(mem_wmask), 32'd0);
    @(posedge clk);
    rst  <= 1'b0;
    inst <= enc_i(op_imm, 5'd0, 3'b000, 5'd0, 12'h000);
    @(negedge clk);
    check("pc after reset", pc, 32'h8000_0000);
    exp_pc = 32'h8000_0004;  // the nop retires at the next edge
    imm = 12'($urandom);
    run(enc_i(op_imm, 5'd5, 3'b000, 5'd0, imm));
    idle_check();
    expv = sext12(imm);
    imm = 12'($urandom);
    run(enc_i(op_imm, 5'd5, 3'b000, 5'd5, imm));
    idle_check();
    expv = expv + sext12(imm);
    store_check(5'd5, expv);
  endtask

  task automatic test_x0();
    run(enc_i(op_imm, 5'd0, 3'b000, 5'd0, 12'($urandom) | 12'h001));
    idle_check();
    store_check(5'd0, 32'd0);
  endtask

  task automatic test_upper();
    logic [19:0] u;
    logic [31:0] expv;
    u = 20'($urandom);
    run(enc_u(op_lui, 5'd6, u));
    idle_check();
    store_check(5'd6, {u, 12'h000});
    u = 20'($urandom);
    run(enc_u(op_auipc, 5'd7, u));
    expv = {u, 12'h000} + cur_pc;
    store_check(5'd7, expv);
  endtask

  task automatic test_jumps();
    logic [20:0] off;
    logic [11:0] imm;
    logic [31:0] base;
    logic [31:0] link;
    off = 21'($urandom);
    off[0] = 1'b0;
    run(enc_j(5'd1, off));
    idle_check();
    link   = cur_pc + 32'd4;
    exp_pc = cur_pc + {{11{off[20]}}, off};
    store_check(5'd1, link);
    base = $urandom;
    load_imm(5'd8, base);
    imm = 12'($urandom);
    imm[0] = ~base[0];  // odd target
    run(enc_i(op_jalr, 5'd9, 3'b000, 5'd8, imm));
    link   = cur_pc + 32'd4;
    exp_pc = base + sext12(imm);  // bit 0 kept as is
    store_check(5'd9, link);
  endtask

  task automatic store_lane(input logic [2:0] f3, input logic [1:0] off,
                            input logic [3:0] mask);
    logic [11:0] imm;
    logic [31:0] addr;
    imm      = 12'($urandom);
    imm[1:0] = off;
    addr     = store_base + sext12(imm);
    run(enc_s(f3, 5'd10, 5'd11, imm));
    check("store strobe", 32'(mem_wen), 32'd1);
    check("store address", mem_addr, addr);
    check("store mask", 32'(mem_wmask), 32'(mask));
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        check($sformatf("store lane %0d", b), 32'(mem_wdata[8*b +: 8]),
              32'(store_data[8*(b - off) +: 8]));
      end
    end
  endtask

  task automatic test_stores();
    store_base = $urandom & 32'hffff_fffc;
    load_imm(5'd10, store_base);
    store_data = $urandom;
    load_imm(5'd11, store_data);
    store_lane(f3_b, 2'd0, 4'b0001);
    store_lane(f3_b, 2'd1, 4'b0010);
    store_lane(f3_b, 2'd2, 4'b0100);
    store_lane(f3_b, 2'd3, 4'b1000);
    store_lane(f3_h, 2'd0, 4'b0011);
    store_lane(f3_h, 2'd2, 4'b1100);
    store_lane(f3_w, 2'd0, 4'b1111);
  endtask

  task automatic load_lane(input logic [2:0] f3, input logic [1:0] off);
    logic [7:0]  idx;
    logic [31:0] sh;
    logic [31:0] expv;
    idx = 8'($urandom);
    run(enc_i(op_load, 5'd13, f3, 5'd0, {2'b00, idx, off}));
    check("load strobe", 32'(mem_ren), 32'd1);
    check("load address", mem_addr, {22'd0, idx, off});
    sh = dmem[idx] >> (8 * off);  // addressed lane moved down to bit 0
    case (f3)
      f3_b:    expv = {{24{sh[7]}}, sh[7:0]};
      f3_bu:   expv = {24'd0, sh[7:0]};
      f3_h:    expv = {{16{sh[15]}}, sh[15:0]};
      f3_hu:   expv = {16'd0, sh[15:0]};
      default: expv = sh;
    endcase
    store_check(5'd13, expv);
  endtask

  task automatic test_loads();
    for (int o = 0; o < 4; o++) begin
      load_lane(f3_b, 2'(o));
      load_lane(f3_bu, 2'(o));
    end
    load_lane(f3_h, 2'd0);
    load_lane(f3_h, 2'd2);
    load_lane(f3_hu, 2'd0);
    load_lane(f3_hu, 2'd2);
    load_lane(f3_w, 2'd0);
  endtask

  initial begin
    void'($urandom(32'hfea9_3760));
    for (int i = 0; i < 256; i++) begin
      dmem[i] = $urandom;
    end
    rst  = 1'b1;
    inst = enc_s(f3_w, 5'd0, 5'd0, 12'h000);  // a store held during reset
    test_reset_and_sequence();
    test_x0();
    test_upper();
    test_jumps();
    test_stores();
    test_loads();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
